// File: Makefile
# Verilator build and run for the ECC memory testbench

VERILATOR ?= verilator
TOP       ?= hci_ecc_mem_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FLIST)) rtl/hci_ecc_macros.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	$(BIN) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+rtl
rtl/hci_ecc_pkg.sv
rtl/hci_mem_intf.sv
rtl/secded_39_32_enc.sv
rtl/secded_39_32_dec.sv
rtl/hci_mem_intf_ecc_enc.sv
rtl/ecc_sram_bank.sv
rtl/hci_ecc_mem_top.sv
sim/hci_ecc_mem_assert.sv
sim/hci_ecc_mem_tb.sv

// File: rtl/ecc_sram_bank.sv
// word wide sram bank on hci with stall input and write fault injection
`timescale 1ns/1ps

`include "hci_ecc_macros.svh"

module ecc_sram_bank (
  input  logic                   clk_i,
  input  logic                   rst_i,
  hci_mem_intf.memory            bus,
  input  logic                   stall_i,
  input  logic [`HCI_ECC_CW-1:0] inj_mask_i
);

  localparam int unsigned DW    = `HCI_ECC_DW;
  localparam int unsigned CW    = `HCI_ECC_CW;
  localparam int unsigned UW    = $bits(bus.user);
  // plain requester user bits below the check bits
  localparam int unsigned PW    = UW - `HCI_ECC_NB;
  // stored entry: plain user bits over the codeword
  localparam int unsigned EW    = CW + PW;
  localparam int unsigned DEPTH = 1 << `HCI_ECC_AW;

  logic [EW-1:0] mem_q [DEPTH];
  logic [EW-1:0] rd_q;
  logic [EW-1:0] wr_word;
  logic [CW-1:0] wr_code;
  logic          wr_req;
  logic          rd_req;
  logic          rvalid_q;

  // stall models a bank conflict, grant ignores req
  assign bus.gnt = ~stall_i;

  assign wr_req = bus.req & bus.gnt & ~bus.wen;
  assign rd_req = bus.req & bus.gnt & bus.wen;

  // injected faults land only on the codeword bits
  assign wr_code = {bus.user[UW-1:PW], bus.data} ^ inj_mask_i;
  assign wr_word = {bus.user[PW-1:0], wr_code};

  always_ff @(posedge clk_i) begin
    if (wr_req) begin
      mem_q[bus.add] <= wr_word;
    end
  end

  // read data held until the next granted read
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rd_q <= mem_q[bus.add];
    end
  end

  // one response pulse per granted read
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_req;
    end
  end

  assign bus.r_valid = rvalid_q;
  assign bus.r_data  = rd_q[DW-1:0];
  // check bits back into the msbs, plain user bits below
  assign bus.r_user  = {rd_q[CW-1:DW], rd_q[EW-1:CW]};

endmodule

// File: rtl/hci_ecc_macros.svh
// hci ecc memory subsystem: shared widths and the hsiao parity masks
`ifndef HCI_ECC_MACROS_SVH
`define HCI_ECC_MACROS_SVH

// data word width
`define HCI_ECC_DW 32
// word address width, 256 words
`define HCI_ECC_AW 8
// requester side user width
`define HCI_ECC_UW 4
// check bits of the 39/32 code
`define HCI_ECC_NB 7
// full codeword width
`define HCI_ECC_CW (`HCI_ECC_DW + `HCI_ECC_NB)

// data bit masks per check bit, check bit 6 first
// every data column has weight 3 and all columns are distinct
`define HCI_ECC_H_DATA {32'h98505586, 32'h2DCC624C, 32'hC2C1323B, 32'h31234ED1, \
                        32'h413D89AA, 32'hDEBA8050, 32'h2606BD25}

`endif

// File: rtl/hci_ecc_mem_top.sv
// ecc protected hci memory subsystem: plain ports, ecc wrapper and sram bank
`timescale 1ns/1ps

`include "hci_ecc_macros.svh"

module hci_ecc_mem_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // request side
  input  logic                   req_i,
  output logic                   gnt_o,
  input  logic [`HCI_ECC_AW-1:0] add_i,
  input  logic                   wen_i,
  input  logic [`HCI_ECC_DW-1:0] data_i,
  input  logic [`HCI_ECC_UW-1:0] user_i,
  // response side
  output logic [`HCI_ECC_DW-1:0] r_data_o,
  output logic [`HCI_ECC_UW-1:0] r_user_o,
  output logic                   r_valid_o,
  output logic [`HCI_ECC_NB-1:0] syndrome_o,
  output logic [1:0]             err_o,
  // bank conflict and fault injection controls
  input  logic                   stall_i,
  input  logic [`HCI_ECC_CW-1:0] inj_mask_i
);

  // requester side bus, plain user bits only
  hci_mem_intf #(
    .UW (`HCI_ECC_UW)
  ) bus_req ();

  // bank side bus, check bits appended above the user bits
  hci_mem_intf #(
    .UW (`HCI_ECC_UW + `HCI_ECC_NB)
  ) bus_mem ();

  assign bus_req.req  = req_i;
  assign bus_req.add  = add_i;
  assign bus_req.wen  = wen_i;
  assign bus_req.data = data_i;
  assign bus_req.user = user_i;

  assign gnt_o     = bus_req.gnt;
  assign r_data_o  = bus_req.r_data;
  assign r_user_o  = bus_req.r_user;
  assign r_valid_o = bus_req.r_valid;

  hci_mem_intf_ecc_enc hci_mem_intf_ecc_enc_inst (
    .bus_in     (bus_req),
    .bus_out    (bus_mem),
    .syndrome_o (syndrome_o),
    .err_o      (err_o)
  );

  ecc_sram_bank ecc_sram_bank_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .bus        (bus_mem),
    .stall_i    (stall_i),
    .inj_mask_i (inj_mask_i)
  );

endmodule

// File: rtl/hci_ecc_pkg.sv
// hci ecc package: codeword type shared by encoder, decoder and wrapper
// err_o coding used across the design: bit 0 corrected single error,
// bit 1 uncorrectable double error
package hci_ecc_pkg;

  `include "hci_ecc_macros.svh"

  // check bits sit above the data bits
  typedef struct packed {
    logic [`HCI_ECC_NB-1:0] chk;
    logic [`HCI_ECC_DW-1:0] data;
  } ecc_fields_t;

  // one 39 bit word, seen either as a flat vector or as its fields
  // raw view is used for syndrome columns and bit flips
  typedef union packed {
    logic [`HCI_ECC_CW-1:0] raw;
    ecc_fields_t            f;
  } ecc_word_u;

endpackage

// File: rtl/hci_mem_intf.sv
// hci memory interface: req/gnt request channel plus registered read response
`timescale 1ns/1ps

`include "hci_ecc_macros.svh"

interface hci_mem_intf #(
  parameter int unsigned UW = `HCI_ECC_UW
);

  // request channel
  logic                   req;
  logic                   gnt;
  logic [`HCI_ECC_AW-1:0] add;
  // high means read, low means write
  logic                   wen;
  logic [`HCI_ECC_DW-1:0] data;
  logic [UW-1:0]          user;

  // response channel, valid one cycle after a granted read
  logic [`HCI_ECC_DW-1:0] r_data;
  logic [UW-1:0]          r_user;
  logic                   r_valid;

  // side that issues requests
  modport requester (
    output req,
    output add,
    output wen,
    output data,
    output user,
    input  gnt,
    input  r_data,
    input  r_user,
    input  r_valid
  );

  // side that serves requests
  modport memory (
    input  req,
    input  add,
    input  wen,
    input  data,
    input  user,
    output gnt,
    output r_data,
    output r_user,
    output r_valid
  );

endinterface

// File: rtl/hci_mem_intf_ecc_enc.sv
// ecc wrapper on hci: encodes writes into data plus user msbs and
// decodes read responses, no added latency
`timescale 1ns/1ps

`include "hci_ecc_macros.svh"

module hci_mem_intf_ecc_enc (
  hci_mem_intf.memory             bus_in,
  hci_mem_intf.requester          bus_out,
  output logic [`HCI_ECC_NB-1:0] syndrome_o,
  output logic [1:0]             err_o
);

  import hci_ecc_pkg::*;

  localparam int unsigned UW_IN  = $bits(bus_in.user);
  localparam int unsigned UW_OUT = $bits(bus_out.user);

  // bank side must carry the requester user bits plus the check bits
  if (UW_OUT != UW_IN + `HCI_ECC_NB) begin : g_uw_check
    $fatal(1, "bus_out user width must be bus_in user width plus check bits");
  end

  ecc_word_u                wr_code;
  ecc_word_u                rd_code;
  logic [`HCI_ECC_NB-1:0]   dec_syn;
  logic [1:0]               dec_err;

  // handshake and address pass straight through
  assign bus_out.req    = bus_in.req;
  assign bus_in.gnt     = bus_out.gnt;
  assign bus_out.add    = bus_in.add;
  assign bus_out.wen    = bus_in.wen;
  assign bus_in.r_valid = bus_out.r_valid;

  // write path, check bits go into the user msbs
  secded_39_32_enc secded_39_32_enc_inst (
    .data_i (bus_in.data),
    .code_o (wr_code)
  );

  assign bus_out.data = wr_code.f.data;
  assign bus_out.user = {wr_code.f.chk, bus_in.user};

  // read path, codeword rebuilt from r_user msbs and r_data
  assign rd_code.raw = {bus_out.r_user[UW_OUT-1:UW_IN], bus_out.r_data};

  secded_39_32_dec secded_39_32_dec_inst (
    .code_i     (rd_code),
    .data_o     (bus_in.r_data),
    .syndrome_o (dec_syn),
    .err_o      (dec_err)
  );

  assign bus_in.r_user = bus_out.r_user[UW_IN-1:0];

  // status only means something alongside a valid response
  assign syndrome_o = bus_out.r_valid ? dec_syn : '0;
  assign err_o      = bus_out.r_valid ? dec_err : 2'b00;

endmodule

// File: rtl/secded_39_32_dec.sv
// hsiao secded 39/32 decoder: syndrome, single bit correction and
// double error detection, purely combinational
`timescale 1ns/1ps

`include "hci_ecc_macros.svh"

module secded_39_32_dec (
  input  hci_ecc_pkg::ecc_word_u  code_i,
  output logic [`HCI_ECC_DW-1:0] data_o,
  output logic [`HCI_ECC_NB-1:0] syndrome_o,
  output logic [1:0]             err_o
);

  import hci_ecc_pkg::*;

  localparam int unsigned DW = `HCI_ECC_DW;
  localparam int unsigned NB = `HCI_ECC_NB;

  // same parity rows as the encoder
  localparam logic [NB-1:0][DW-1:0] H_DATA = `HCI_ECC_H_DATA;

  logic [NB-1:0] chk_calc;
  logic [NB-1:0] syn;
  ecc_word_u     fixed;

  // parity recomputed over the received data bits
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      chk_calc[i] = ^(code_i.f.data & H_DATA[i]);
    end
  end

  // zero when stored and recomputed check bits agree
  assign syn = chk_calc ^ code_i.f.chk;

  // flip the one bit whose H column equals the syndrome
  always_comb begin : flip
    logic [NB-1:0] col;
    fixed = code_i;
    col   = '0;
    // data columns are read out of the parity rows
    for (int j = 0; j < DW; j++) begin
      for (int i = 0; i < NB; i++) begin
        col[i] = H_DATA[i][j];
      end
      if (syn == col) begin
        fixed.raw[j] = ~code_i.raw[j];
      end
    end
    // check bit columns are one-hot
    for (int k = 0; k < NB; k++) begin
      if (syn == (NB'(1) << k)) begin
        fixed.raw[DW+k] = ~code_i.raw[DW+k];
      end
    end
  end

  // even weight syndromes match no column, so a double error leaves
  // the data as it was read
  assign data_o = fixed.f.data;

  assign syndrome_o = syn;

  // odd weight means single error, even nonzero means double
  assign err_o[0] = ^syn;
  assign err_o[1] = ~(^syn) & (|syn);

endmodule

// File: rtl/secded_39_32_enc.sv
// hsiao secded 39/32 encoder, purely combinational
`timescale 1ns/1ps

`include "hci_ecc_macros.svh"

module secded_39_32_enc (
  input  logic [`HCI_ECC_DW-1:0] data_i,
  output hci_ecc_pkg::ecc_word_u code_o
);

  localparam int unsigned DW = `HCI_ECC_DW;
  localparam int unsigned NB = `HCI_ECC_NB;

  // row i selects the data bits covered by check bit i
  localparam logic [NB-1:0][DW-1:0] H_DATA = `HCI_ECC_H_DATA;

  always_comb begin
    // data travels unchanged in the low bits
    code_o.f.data = data_i;
    // each check bit is the parity of its row
    for (int i = 0; i < NB; i++) begin
      code_o.f.chk[i] = ^(data_i & H_DATA[i]);
    end
  end

endmodule

// File: sim/hci_ecc_mem_assert.sv
// protocol and error flag properties for the ecc memory top level
`timescale 1ns/1ps

`include "hci_ecc_macros.svh"

module hci_ecc_mem_assert (
  input logic                   clk_i,
  input logic                   rst_i,
  input logic                   req_i,
  input logic                   wen_i,
  input logic                   gnt_o,
  input logic                   r_valid_o,
  input logic [`HCI_ECC_NB-1:0] syndrome_o,
  input logic [1:0]             err_o
);

  // number of failed properties so far
  int unsigned fail_cnt = 0;
  logic        rd_xfer;

  // read handshake in this cycle
  assign rd_xfer = req_i & gnt_o & wen_i;

  // response exactly one cycle after a granted read, and only then
  a_rvalid_after_read: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_xfer |=> r_valid_o)
    else begin
      $error("r_valid_o did not follow a granted read");
      fail_cnt++;
    end

  a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    !rd_xfer |=> !r_valid_o)
    else begin
      $error("r_valid_o high without a granted read one cycle before");
      fail_cnt++;
    end

  // status outputs stay quiet between responses
  a_quiet_status: assert property (@(posedge clk_i) disable iff (rst_i)
    !r_valid_o |-> (err_o == 2'b00 && syndrome_o == '0))
    else begin
      $error("err_o or syndrome_o nonzero while r_valid_o is low");
      fail_cnt++;
    end

  // zero syndrome and no error flag go together
  a_syndrome_matches_err: assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_o |-> ((syndrome_o == '0) == (err_o == 2'b00)))
    else begin
      $error("syndrome_o and err_o disagree on a valid read");
      fail_cnt++;
    end

  a_err_onehot: assert property (@(posedge clk_i) disable iff (rst_i) err_o != 2'b11)
    else begin
      $error("err_o has both bits set");
      fail_cnt++;
    end

endmodule

bind hci_ecc_mem_top hci_ecc_mem_assert hci_ecc_mem_assert_inst (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .req_i      (req_i),
  .wen_i      (wen_i),
  .gnt_o      (gnt_o),
  .r_valid_o  (r_valid_o),
  .syndrome_o (syndrome_o),
  .err_o      (err_o)
);

// File: sim/hci_ecc_mem_tb.sv
// testbench for the ecc protected hci memory with random traffic, fault
// injection, stalls and a scoreboard of the last word per address
`timescale 1ns/1ps

`include "hci_ecc_macros.svh"

module hci_ecc_mem_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RST_CYCLES   = 16;
  localparam int CW           = `HCI_ECC_CW;
  localparam int N_CLEAN      = 32;
  localparam int N_DOUBLE     = 8;
  localparam int N_STALL_RUNS = 3;
  localparam int MAX_STALL    = 16;
  localparam int N_B2B        = 16;
  localparam int N_RAW        = 8;
  // every write and read counts as one transaction
  localparam int NUM_TXN      = 2 * (N_CLEAN + CW + N_DOUBLE + N_B2B + N_RAW) + N_STALL_RUNS;
  localparam int WATCHDOG_NS  = (NUM_TXN + N_STALL_RUNS * MAX_STALL + 100) * CLK_PERIOD;

  logic                   clk_i;
  logic                   rst_i;
  logic                   req_i;
  logic                   gnt_o;
  logic [`HCI_ECC_AW-1:0] add_i;
  logic                   wen_i;
  logic [`HCI_ECC_DW-1:0] data_i;
  logic [`HCI_ECC_UW-1:0] user_i;
  logic [`HCI_ECC_DW-1:0] r_data_o;
  logic [`HCI_ECC_UW-1:0] r_user_o;
  logic                   r_valid_o;
  logic [`HCI_ECC_NB-1:0] syndrome_o;
  logic [1:0]             err_o;
  logic                   stall_i;
  logic [CW-1:0]          inj_mask_i;

  // scoreboard of the last write per address and the error class it reads back
  logic [31:0] sb_data [256];
  logic [3:0]  sb_user [256];
  logic [1:0]  sb_err  [256];
  logic [7:0]  clean_addr [N_CLEAN];
  // expected responses in issue order
  logic [31:0] exp_data_q [$];
  logic [3:0]  exp_user_q [$];
  logic [1:0]  exp_err_q  [$];
  logic [31:0] rng_state = 32'd34;
  int          rsp_fail_cnt = 0;
  int          stim_fail_cnt = 0;
  int          rsp_cnt = 0;

  hci_ecc_mem_top hci_ecc_mem_top_inst (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // one flipped bit is corrected and two are only detected
  function automatic logic [1:0] err_class(input logic [CW-1:0] mask);
    case ($countones(mask))
      0:       return 2'b00;
      1:       return 2'b01;
      default: return 2'b10;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act, inout int cnt);
    assert (exp == act) else begin
      $display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
      cnt++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // returns at the falling edge of the granted cycle
  task automatic wait_grant();
    @(negedge clk_i);
    while (!gnt_o) @(negedge clk_i);
  endtask

  task automatic do_write(input logic [7:0] addr, input logic [31:0] data,
                          input logic [3:0] user, input logic [CW-1:0] mask);
    req_i      = 1'b1;
    wen_i      = 1'b0;
    add_i      = addr;
    data_i     = data;
    user_i     = user;
    inj_mask_i = mask;
    wait_grant();
    sb_data[addr] = data;
    sb_user[addr] = user;
    sb_err[addr]  = err_class(mask);
    next_cycle();
  endtask

  task automatic do_read(input logic [7:0] addr);
    req_i      = 1'b1;
    wen_i      = 1'b1;
    add_i      = addr;
    inj_mask_i = '0;
    wait_grant();
    exp_data_q.push_back(sb_data[addr]);
    exp_user_q.push_back(sb_user[addr]);
    exp_err_q.push_back(sb_err[addr]);
    next_cycle();
  endtask

  task automatic idle(input int n);
    req_i      = 1'b0;
    inj_mask_i = '0;
    repeat (n) next_cycle();
  endtask

  // responses are checked at the falling edge where outputs are stable
  always @(negedge clk_i) begin : response_check
    logic [31:0] e_data;
    logic [3:0]  e_user;
    logic [1:0]  e_err;
    if (!rst_i && r_valid_o) begin
      rsp_cnt++;
      if (exp_data_q.size() == 0) begin
        $display("read response at %0t with no read outstanding", $time);
        rsp_fail_cnt++;
      end else begin
        e_data = exp_data_q.pop_front();
        e_user = exp_user_q.pop_front();
        e_err  = exp_err_q.pop_front();
        check_value("r_user_o", 64'(e_user), 64'(r_user_o), rsp_fail_cnt);
        // a double error returns the data uncorrected
        if (e_err != 2'b10) check_value("r_data_o", 64'(e_data), 64'(r_data_o), rsp_fail_cnt);
        check_value("err_o", 64'(e_err), 64'(err_o), rsp_fail_cnt);
        if (e_err != 2'b00) begin
          assert (syndrome_o != '0) else begin
            $display("syndrome_o is zero at %0t although a fault was stored", $time);
            rsp_fail_cnt++;
          end
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] d;
    logic [7:0]  a;
    logic [7:0]  base;
    int          p;
    int          q;
    int          n;
    int          total;
    clk_i      = 1'b0;
    rst_i      = 1'b1;
    req_i      = 1'b0;
    add_i      = '0;
    wen_i      = 1'b0;
    data_i     = '0;
    user_i     = '0;
    stall_i    = 1'b0;
    inj_mask_i = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    // clean path with all writes first and then all reads
    for (int i = 0; i < N_CLEAN; i++) begin
      r = rand32();
      clean_addr[i] = r[7:0];
      d = rand32();
      do_write(r[7:0], d, r[11:8], '0);
    end
    for (int i = 0; i < N_CLEAN; i++) do_read(clean_addr[i]);
    idle(2);

    // one stored fault per codeword bit
    for (int b = 0; b < CW; b++) begin
      r = rand32();
      d = rand32();
      do_write(r[7:0], d, r[11:8], CW'(1) << b);
      do_read(r[7:0]);
    end

    // two distinct stored faults
    for (int i = 0; i < N_DOUBLE; i++) begin
      p = int'(rand32() % 32'(CW));
      q = p;
      while (q == p) q = int'(rand32() % 32'(CW));
      r = rand32();
      d = rand32();
      do_write(r[7:0], d, r[11:8], (CW'(1) << p) | (CW'(1) << q));
      do_read(r[7:0]);
    end

    // read held off by a stall and then released
    for (int i = 0; i < N_STALL_RUNS; i++) begin
      idle(2);
      n = 1 + int'(rand32() % 32'(MAX_STALL));
      a = clean_addr[i];
      stall_i = 1'b1;
      req_i   = 1'b1;
      wen_i   = 1'b1;
      add_i   = a;
      repeat (n) begin
        @(negedge clk_i);
        check_value("gnt_o", 64'(0), 64'(gnt_o), stim_fail_cnt);
        check_value("r_valid_o", 64'(0), 64'(r_valid_o), stim_fail_cnt);
        next_cycle();
      end
      stall_i = 1'b0;
      do_read(a);
    end
    idle(2);

    // back to back writes and reads over a run of addresses
    r = rand32();
    base = r[7:0];
    for (int i = 0; i < N_B2B; i++) begin
      d = rand32();
      r = rand32();
      do_write(base + 8'(i), d, r[3:0], '0);
    end
    for (int i = 0; i < N_B2B; i++) do_read(base + 8'(i));

    // read in the cycle right after the write
    for (int i = 0; i < N_RAW; i++) begin
      r = rand32();
      d = rand32();
      do_write(r[7:0], d, r[15:12], '0);
      do_read(r[7:0]);
    end
    idle(4);

    assert (exp_data_q.size() == 0) else begin
      $display("%0d read responses never arrived", exp_data_q.size());
      stim_fail_cnt++;
    end
    total = rsp_fail_cnt + stim_fail_cnt +
            int'(hci_ecc_mem_top_inst.hci_ecc_mem_assert_inst.fail_cnt);
    $display("failures: response checks %0d, control checks %0d, assertions %0d, responses %0d",
             rsp_fail_cnt, stim_fail_cnt,
             hci_ecc_mem_top_inst.hci_ecc_mem_assert_inst.fail_cnt, rsp_cnt);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule
